// File: include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ----------------------------------------
// Core widths
// ----------------------------------------

// One word for data and for instructions
`define CPU_W 16

// Sixteen architectural registers
`define CPU_RW 4

// ----------------------------------------
// Memory geometry, same for both arrays
// ----------------------------------------
`define CPU_AW 8      // Word index, byte address bits 8:1
`define CPU_DEPTH 256 // Words per array

`endif

// File: rtl/cpu_pkg.sv
package cpu_pkg;

	// ----------------------------------------
	// Opcodes in bits 15:12
	// ----------------------------------------
	typedef enum logic [3:0] {
		OP_ADD = 4'h0, // Rd = Rs + Rt
		OP_SUB = 4'h1, // Rd = Rs - Rt
		OP_XOR = 4'h2,
		OP_SLL = 4'h4, // Shift amount in imm4
		OP_SRA = 4'h5, // Arithmetic right shift
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA, // Byte into upper half
		OP_LLB = 4'hB, // Byte into lower half
		OP_B   = 4'hC, // PC relative conditional branch
		OP_HLT = 4'hF
	} opcode_e;
	// Codes 3, 6, 7, D, E fall through as no-ops

	// ----------------------------------------
	// Branch condition in bits 11:9
	// ----------------------------------------
	typedef enum logic [2:0] {
		COND_NE     = 3'b000, // Taken on Z clear
		COND_EQ     = 3'b001, // Taken on Z set
		COND_ALWAYS = 3'b111
	} cond_e;

	// Condition codes held in execute
	typedef struct packed {
		logic z; // Result was zero
		logic v; // Signed overflow, add and sub only
		logic n; // Sign bit of result
	} flags_t;

endpackage

// File: rtl/pipe_if.sv
`include "cpu_defs.svh"

// ----------------------------------------
// ID/EX pipeline register contents
// ----------------------------------------
interface dx_if;
	logic               valid;     // Slot holds a real instruction
	logic [`CPU_W-1:0]  pc;        // Address of next instruction
	logic [`CPU_W-1:0]  instr;
	logic [`CPU_W-1:0]  data1;     // Regfile read of src1
	logic [`CPU_W-1:0]  data2;     // Regfile read of src2
	logic [`CPU_RW-1:0] src1;
	logic [`CPU_RW-1:0] src2;
	logic [`CPU_RW-1:0] dst;
	logic               regwrite;
	logic               memtoreg;  // Load
	logic               memwrite;  // Store

	// Decode drives and reads back for hazard checks
	modport source (
		output valid, pc, instr,
		output data1, data2, src1, src2, dst,
		output regwrite, memtoreg, memwrite
	);

	modport sink (
		input valid, pc, instr,
		input data1, data2, src1, src2, dst,
		input regwrite, memtoreg, memwrite
	);
endinterface

// ----------------------------------------
// EX/MEM pipeline register contents
// ----------------------------------------
interface xm_if;
	logic [`CPU_W-1:0]  result;     // ALU or byte load value
	logic [`CPU_W-1:0]  addr;       // Byte address for LW and SW
	logic [`CPU_W-1:0]  store_data;
	logic [`CPU_RW-1:0] dst;
	logic               regwrite;
	logic               memtoreg;
	logic               memwrite;

	// Execute also reads these back for MEM forwarding
	modport source (
		output result, addr, store_data, dst,
		output regwrite, memtoreg, memwrite
	);

	modport sink (
		input result, addr, store_data, dst,
		input regwrite, memtoreg, memwrite
	);
endinterface

// File: rtl/fetch_stage.sv
`include "cpu_defs.svh"

module fetch_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               stall,         // Load-use hold
	input  logic               halted,
	input  logic               branch_taken,
	input  logic [`CPU_W-1:0]  branch_target,
	input  logic               prog_we,       // Program loader port
	input  logic [`CPU_AW-1:0] prog_addr,
	input  logic [`CPU_W-1:0]  prog_data,
	output logic [`CPU_W-1:0]  if_pc,         // PC + 2 of the fetched word
	output logic [`CPU_W-1:0]  if_instr,
	output logic               if_valid,
	output logic [`CPU_W-1:0]  pc_out
);

	logic [`CPU_W-1:0] pc;
	logic [`CPU_W-1:0] pc_plus2;
	logic [`CPU_W-1:0] imem [`CPU_DEPTH]; // Word addressed
	logic              advance;

	assign pc_plus2 = pc + `CPU_W'd2;
	assign advance  = !stall && !halted;
	assign pc_out   = pc;

	// Loader writes, pipeline only reads
	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	// PC and IF/ID valid
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc       <= '0;
			if_valid <= 1'b0;
		end else if (branch_taken) begin
			pc       <= branch_target; // Redirect wins over hold
			if_valid <= 1'b0;          // Drop the wrong-path fetch
		end else if (advance) begin
			pc       <= pc_plus2;
			if_valid <= 1'b1;
		end
	end

	// IF/ID payload, meaningful only with if_valid
	always_ff @(posedge clk) begin
		if (advance) begin
			if_instr <= imem[pc[`CPU_AW:1]];
			if_pc    <= pc_plus2;
		end
	end

endmodule

// File: rtl/decode_stage.sv
`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [`CPU_W-1:0]  if_pc,
	input  logic [`CPU_W-1:0]  if_instr,
	input  logic               if_valid,
	input  logic               branch_taken, // Flush from execute
	input  logic               wb_regwrite,
	input  logic [`CPU_RW-1:0] wb_dst,
	input  logic [`CPU_W-1:0]  wb_data,
	input  logic [`CPU_RW-1:0] dbg_sel,
	output logic               stall,
	output logic               halted,
	output logic [`CPU_W-1:0]  dbg_data,
	dx_if.source               dx
);

	opcode_e            op;
	logic [`CPU_RW-1:0] src1, src2, dst;
	logic               use1, use2;        // Source really read as a register
	logic               regwrite, memtoreg, memwrite;
	logic [`CPU_W-1:0]  rdata1, rdata2;
	logic [`CPU_W-1:0]  regs [2**`CPU_RW];

	// ----------------------------------------
	// Control decode
	// ----------------------------------------
	always_comb begin
		op       = opcode_e'(if_instr[15:12]);
		dst      = if_instr[11:8];
		regwrite = 1'b0;
		memtoreg = 1'b0;
		memwrite = 1'b0;
		use1     = 1'b0;
		use2     = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_XOR: begin
				regwrite = 1'b1;
				use1     = 1'b1;
				use2     = 1'b1;
			end
			OP_SLL, OP_SRA: begin
				regwrite = 1'b1;
				use1     = 1'b1; // Low nibble is the shift amount
			end
			OP_LW: begin
				regwrite = 1'b1;
				memtoreg = 1'b1;
				use2     = 1'b1; // Base register
			end
			OP_SW: begin
				memwrite = 1'b1;
				use1     = 1'b1; // Store data
				use2     = 1'b1; // Base register
			end
			OP_LHB, OP_LLB: begin
				regwrite = 1'b1;
				use1     = 1'b1; // Keeps the other byte of Rd
			end
			default: ; // B, HLT and unused codes
		endcase
		if (dst == '0)
			regwrite = 1'b0; // R0 is hardwired
		// SW, LHB and LLB take Rd as first source
		src1 = (op == OP_SW || op == OP_LHB || op == OP_LLB) ? if_instr[11:8] : if_instr[7:4];
		src2 = (op == OP_SW || op == OP_LW) ? if_instr[7:4] : if_instr[3:0];
	end

	// ----------------------------------------
	// Register file
	// ----------------------------------------
	// Same-cycle writeback value bypasses the array
	function automatic logic [`CPU_W-1:0] rf_read(input logic [`CPU_RW-1:0] sel);
		logic [`CPU_W-1:0] val;
		if (sel == '0)
			val = '0;
		else if (wb_regwrite && wb_dst == sel)
			val = wb_data;
		else
			val = regs[sel];
		return val;
	endfunction

	always_comb begin
		rdata1   = rf_read(src1);
		rdata2   = rf_read(src2);
		dbg_data = rf_read(dbg_sel); // Debug port sees the same view
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**`CPU_RW; i++)
				regs[i] <= '0;
		end else if (wb_regwrite && wb_dst != '0) begin
			regs[wb_dst] <= wb_data;
		end
	end

	// Load in EX feeding a source in ID costs one bubble
	assign stall = if_valid && dx.valid && dx.memtoreg && dx.regwrite &&
	               ((use1 && src1 == dx.dst) || (use2 && src2 == dx.dst));

	// Sticky once HLT moves on to EX
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			halted <= 1'b0;
		else if (if_valid && op == OP_HLT && !branch_taken && !stall)
			halted <= 1'b1;
	end

	// ----------------------------------------
	// ID/EX register
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dx.valid    <= 1'b0;
			dx.regwrite <= 1'b0;
			dx.memtoreg <= 1'b0;
			dx.memwrite <= 1'b0;
		end else if (branch_taken || stall || halted || !if_valid) begin
			dx.valid    <= 1'b0; // Bubble
			dx.regwrite <= 1'b0;
			dx.memtoreg <= 1'b0;
			dx.memwrite <= 1'b0;
		end else begin
			dx.valid    <= 1'b1;
			dx.regwrite <= regwrite;
			dx.memtoreg <= memtoreg;
			dx.memwrite <= memwrite;
		end
	end

	always_ff @(posedge clk) begin
		dx.pc    <= if_pc;
		dx.instr <= if_instr;
		dx.data1 <= rdata1;
		dx.data2 <= rdata2;
		dx.src1  <= src1;
		dx.src2  <= src2;
		dx.dst   <= dst;
	end

endmodule

// File: rtl/execute_stage.sv
`include "cpu_defs.svh"

module execute_stage import cpu_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               wb_regwrite,   // Writeback group for forwarding
	input  logic [`CPU_RW-1:0] wb_dst,
	input  logic [`CPU_W-1:0]  wb_data,
	output logic               branch_taken,
	output logic [`CPU_W-1:0]  branch_target,
	dx_if.sink                 dx,
	xm_if.source               xm
);

	opcode_e           op;
	cond_e             cond;
	flags_t            flags, flags_nxt;
	logic              flag_we;
	logic              cond_true;
	logic [`CPU_W-1:0] opa, opb;      // Operands after forwarding
	logic [`CPU_W-1:0] sum, diff;
	logic [`CPU_W-1:0] result;
	logic [`CPU_W-1:0] addr;

	// ----------------------------------------
	// Forwarding
	// ----------------------------------------
	always_comb begin
		opa = dx.data1;
		opb = dx.data2;
		if (wb_regwrite && wb_dst == dx.src1)
			opa = wb_data;
		if (wb_regwrite && wb_dst == dx.src2)
			opb = wb_data;
		if (xm.regwrite && xm.dst == dx.src1) // Younger result wins
			opa = xm.result;
		if (xm.regwrite && xm.dst == dx.src2)
			opb = xm.result;
	end

	// ----------------------------------------
	// ALU and byte loads
	// ----------------------------------------
	always_comb begin
		op        = opcode_e'(dx.instr[15:12]);
		sum       = opa + opb;
		diff      = opa - opb;
		result    = '0;
		flags_nxt = flags; // V survives logic ops
		flag_we   = 1'b0;
		case (op)
			OP_ADD: begin
				result      = sum;
				flags_nxt.v = (opa[`CPU_W-1] == opb[`CPU_W-1]) && (sum[`CPU_W-1] != opa[`CPU_W-1]);
				flag_we     = 1'b1;
			end
			OP_SUB: begin
				result      = diff;
				flags_nxt.v = (opa[`CPU_W-1] != opb[`CPU_W-1]) && (diff[`CPU_W-1] != opa[`CPU_W-1]);
				flag_we     = 1'b1;
			end
			OP_XOR: begin
				result  = opa ^ opb;
				flag_we = 1'b1;
			end
			OP_SLL: begin
				result  = opa << dx.instr[3:0];
				flag_we = 1'b1;
			end
			OP_SRA: begin
				result  = $signed(opa) >>> dx.instr[3:0];
				flag_we = 1'b1;
			end
			OP_LHB:  result = {dx.instr[7:0], opa[7:0]};
			OP_LLB:  result = {opa[`CPU_W-1:8], dx.instr[7:0]};
			default: result = '0;
		endcase
		flags_nxt.z = (result == '0);
		flags_nxt.n = result[`CPU_W-1];
	end

	// Base with bit 0 cleared plus offset in words
	assign addr = {opb[`CPU_W-1:1], 1'b0} + {{(`CPU_W-5){dx.instr[3]}}, dx.instr[3:0], 1'b0};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			flags <= '0;
		else if (dx.valid && flag_we)
			flags <= flags_nxt;
	end

	// ----------------------------------------
	// Branch decision
	// ----------------------------------------
	always_comb begin
		cond = cond_e'(dx.instr[11:9]);
		case (cond)
			COND_NE:     cond_true = !flags.z;
			COND_EQ:     cond_true = flags.z;
			COND_ALWAYS: cond_true = 1'b1;
			default:     cond_true = 1'b0; // Unused codes never branch
		endcase
	end

	assign branch_taken  = dx.valid && op == OP_B && cond_true;
	assign branch_target = dx.pc + {{(`CPU_W-10){dx.instr[8]}}, dx.instr[8:0], 1'b0};

	// EX/MEM register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			xm.regwrite <= 1'b0;
			xm.memtoreg <= 1'b0;
			xm.memwrite <= 1'b0;
		end else begin
			xm.regwrite <= dx.valid && dx.regwrite; // Bubbles carry no enables
			xm.memtoreg <= dx.valid && dx.memtoreg;
			xm.memwrite <= dx.valid && dx.memwrite;
		end
	end

	always_ff @(posedge clk) begin
		xm.result     <= result;
		xm.addr       <= addr;
		xm.store_data <= opa; // Rd value for SW
		xm.dst        <= dx.dst;
	end

endmodule

// File: rtl/memory_stage.sv
`include "cpu_defs.svh"

module memory_stage (
	input  logic               clk,
	input  logic               arst_n,
	output logic               wb_regwrite,
	output logic [`CPU_RW-1:0] wb_dst,
	output logic [`CPU_W-1:0]  wb_data,
	xm_if.sink                 xm
);

	logic [`CPU_W-1:0]  dmem [`CPU_DEPTH];
	logic [`CPU_AW-1:0] widx;     // Word index from byte address
	logic [`CPU_W-1:0]  rdata;
	logic [`CPU_W-1:0]  mem_data; // Value headed for writeback

	// ----------------------------------------
	// Data memory
	// ----------------------------------------
	assign widx  = xm.addr[`CPU_AW:1];
	assign rdata = dmem[widx]; // Asynchronous read

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU_DEPTH; i++)
				dmem[i] <= '0;
		end else if (xm.memwrite) begin
			dmem[widx] <= xm.store_data;
		end
	end

	// Loaded word or EX result
	assign mem_data = xm.memtoreg ? rdata : xm.result;

	// ----------------------------------------
	// MEM/WB register
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_regwrite <= 1'b0;
		else
			wb_regwrite <= xm.regwrite;
	end

	// Drives the regfile write next cycle
	always_ff @(posedge clk) begin
		wb_dst  <= xm.dst;
		wb_data <= mem_data;
	end

endmodule

// File: rtl/cpu.sv
`include "cpu_defs.svh"

module cpu (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               prog_we,   // Program load, used during reset
	input  logic [`CPU_AW-1:0] prog_addr,
	input  logic [`CPU_W-1:0]  prog_data,
	input  logic [`CPU_RW-1:0] dbg_sel,   // Register debug read
	output logic               hlt,
	output logic [`CPU_W-1:0]  pc_out,
	output logic [`CPU_W-1:0]  dbg_data
);

	// ----------------------------------------
	// Stage to stage wires
	// ----------------------------------------
	logic [`CPU_W-1:0]  if_pc, if_instr;
	logic               if_valid;
	logic               stall;
	logic               branch_taken;
	logic [`CPU_W-1:0]  branch_target;
	logic               wb_regwrite;
	logic [`CPU_RW-1:0] wb_dst;
	logic [`CPU_W-1:0]  wb_data;

	dx_if dx (); // ID/EX
	xm_if xm (); // EX/MEM

	fetch_stage u_fetch (
		.clk, .arst_n,
		.stall, .halted(hlt), .branch_taken, .branch_target,
		.prog_we, .prog_addr, .prog_data,
		.if_pc, .if_instr, .if_valid, .pc_out
	);

	decode_stage u_decode (
		.clk, .arst_n,
		.if_pc, .if_instr, .if_valid, .branch_taken,
		.wb_regwrite, .wb_dst, .wb_data, .dbg_sel,
		.stall, .halted(hlt), .dbg_data,
		.dx(dx)
	);

	execute_stage u_execute (
		.clk, .arst_n,
		.wb_regwrite, .wb_dst, .wb_data,
		.branch_taken, .branch_target,
		.dx(dx), .xm(xm)
	);

	memory_stage u_memory (
		.clk, .arst_n,
		.wb_regwrite, .wb_dst, .wb_data,
		.xm(xm)
	);

endmodule

// File: bench/cpu_programs.svh
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

// ----------------------------------------
// Program table, one row per test
// ----------------------------------------
localparam int NUM_TESTS   = 7;
localparam int PROG_LEN    = 16; // Words per program, spare slots hold HLT
localparam int NUM_CHECKS  = 4;  // Register and expected value pairs
localparam int RANDOM_TEST = 6;  // Row whose bytes are filled at run time

string test_name [NUM_TESTS] = '{
	"byte_alu", "forwarding", "memory", "branch_eq", "branch_ne", "halt", "random_alu"
};

// Fields: op rd rs rt, op rd imm8, op cond imm9
logic [`CPU_W-1:0] test_prog [NUM_TESTS][PROG_LEN] = '{
	// LLB and LHB constants, then SUB XOR SLL SRA
	'{16'hB134, 16'hA112, 16'hB20F, 16'h0312, 16'h1412, 16'h2512, 16'h4614, 16'hB780,
	  16'hA7F0, 16'h5874, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
	// Dependent chain through MEM, WB and regfile bypass
	'{16'hB105, 16'h0211, 16'h0321, 16'h0431, 16'h1542, 16'h2654, 16'hF000, 16'hF000,
	  16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
	// SW then LW, each load followed by a dependent ADD
	'{16'hB110, 16'hB277, 16'hA2A5, 16'h9212, 16'h8312, 16'h0432, 16'hB501, 16'h951F,
	  16'h861F, 16'h0766, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
	// EQ taken over R4 R5, then EQ not taken
	'{16'hB103, 16'hB203, 16'h1312, 16'hC202, 16'hB411, 16'hB522, 16'hB633, 16'hB804,
	  16'h1981, 16'hC201, 16'hBA55, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
	// NE not taken, then NE taken over R7 R8
	'{16'hB107, 16'hB207, 16'h1312, 16'hC002, 16'hB444, 16'hB501, 16'h1651, 16'hC002,
	  16'hB777, 16'hB888, 16'hB999, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
	// Writes placed after HLT must never land
	'{16'hB121, 16'hB242, 16'hF000, 16'hB363, 16'hB484, 16'h0512, 16'hF000, 16'hF000,
	  16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
	// R1 and R2 bytes patched in, ADD SUB XOR SRA
	'{16'hB100, 16'hA100, 16'hB200, 16'hA200, 16'h0312, 16'h1412, 16'h2512, 16'h5613,
	  16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000}
};

// Registers read back after the halt
logic [`CPU_RW-1:0] test_reg [NUM_TESTS][NUM_CHECKS] = '{
	'{4'd4, 4'd5, 4'd6, 4'd8},
	'{4'd3, 4'd4, 4'd5, 4'd6},
	'{4'd3, 4'd4, 4'd6, 4'd7},
	'{4'd4, 4'd5, 4'd6, 4'd10},
	'{4'd4, 4'd7, 4'd8, 4'd9},
	'{4'd1, 4'd2, 4'd3, 4'd5},
	'{4'd3, 4'd4, 4'd5, 4'd6}
};

logic [`CPU_W-1:0] test_exp [NUM_TESTS][NUM_CHECKS] = '{
	'{16'h1225, 16'h123B, 16'h2340, 16'hFF08},
	'{16'h000F, 16'h0014, 16'h000A, 16'h001E},
	'{16'hA577, 16'h4AEE, 16'h0001, 16'h0002},
	'{16'h0000, 16'h0000, 16'h0033, 16'h0055}, // Skipped slots stay clear
	'{16'h0044, 16'h0000, 16'h0000, 16'h0099},
	'{16'h0021, 16'h0042, 16'h0000, 16'h0000},
	'{16'h0000, 16'h0000, 16'h0000, 16'h0000}  // Computed at run time
};

`endif

// File: bench/cpu_tb.sv
`include "cpu_defs.svh"

module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALT_TIMEOUT = 200; // Cycles from reset release
	localparam int HOLD_CYCLES  = 10;  // Frozen window after hlt

	logic               clk;
	logic               arst_n;
	logic               prog_we;
	logic [`CPU_AW-1:0] prog_addr;
	logic [`CPU_W-1:0]  prog_data;
	logic [`CPU_RW-1:0] dbg_sel;
	logic               hlt;
	logic [`CPU_W-1:0]  pc_out;
	logic [`CPU_W-1:0]  dbg_data;

	int errors;
	int checks;
	int seed;

	`include "cpu_programs.svh"

	cpu uut (
		.clk, .arst_n,
		.prog_we, .prog_addr, .prog_data,
		.dbg_sel, .hlt, .pc_out, .dbg_data
	);

	always #2 clk = ~clk; // 4 ns period

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic check_value(input string what, input logic [`CPU_W-1:0] got,
	                           input logic [`CPU_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Random operands patched into the byte load immediates
	task automatic build_random(input int t);
		logic [`CPU_W-1:0] a, b;
		a = 16'($random(seed));
		b = 16'($random(seed));
		test_prog[t][0][7:0] = a[7:0];  // LLB R1
		test_prog[t][1][7:0] = a[15:8]; // LHB R1
		test_prog[t][2][7:0] = b[7:0];
		test_prog[t][3][7:0] = b[15:8];
		test_exp[t][0] = a + b;         // Wraps at 16 bits
		test_exp[t][1] = a - b;
		test_exp[t][2] = a ^ b;
		test_exp[t][3] = {{3{a[`CPU_W-1]}}, a[`CPU_W-1:3]}; // Sign bits fill from the top
	endtask

	// PC freezes two words past the first HLT since fetch still steps as HLT leaves decode
	function automatic logic [`CPU_W-1:0] halt_pc(input int t);
		int idx;
		idx = PROG_LEN;
		for (int i = PROG_LEN - 1; i >= 0; i--)
			if (test_prog[t][i][15:12] == 4'hF)
				idx = i;
		return `CPU_W'(2 * idx + 4);
	endfunction

	// One program word per cycle while reset is held for 16 cycles
	task automatic load_program(input int t);
		@(posedge clk);
		arst_n <= 1'b0;
		for (int i = 0; i < PROG_LEN; i++) begin
			prog_we   <= 1'b1;
			prog_addr <= `CPU_AW'(i);
			prog_data <= test_prog[t][i];
			@(posedge clk);
		end
		prog_we <= 1'b0;
		arst_n  <= 1'b1; // Last word lands on this edge
	endtask

	task automatic wait_halt(output bit ok);
		int cyc;
		cyc = 0;
		ok  = 1'b0;
		while (cyc < HALT_TIMEOUT && !ok) begin
			@(negedge clk); // Outputs settled
			ok = hlt;
			cyc++;
		end
	endtask

	// hlt stays high and the PC sits still while older instructions drain
	task automatic check_frozen(input int t);
		logic [`CPU_W-1:0] pc_exp;
		pc_exp = halt_pc(t);
		repeat (HOLD_CYCLES) begin
			@(negedge clk);
			check_value("hlt", {15'd0, hlt}, 16'h0001);
			check_value("pc_out", pc_out, pc_exp);
		end
	endtask

	task automatic read_registers(input int t);
		for (int k = 0; k < NUM_CHECKS; k++) begin
			@(posedge clk);
			dbg_sel <= test_reg[t][k];
			@(negedge clk);
			check_value($sformatf("%s R%0d", test_name[t], test_reg[t][k]),
			            dbg_data, test_exp[t][k]);
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		int  errs_before;
		bit  halted_ok;
		clk       = 1'b0;
		arst_n    = 1'b0; // In reset from time zero
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_sel   = '0;
		errors    = 0;
		checks    = 0;
		seed      = 32'h5236;

		for (int t = 0; t < NUM_TESTS; t++) begin
			errs_before = errors;
			if (t == RANDOM_TEST)
				build_random(t);
			load_program(t);
			wait_halt(halted_ok);
			if (!halted_ok) begin
				errors++;
				$display("test %s: program never halted within %0d cycles",
				         test_name[t], HALT_TIMEOUT);
			end else begin
				check_frozen(t);
				read_registers(t);
				if (errors == errs_before)
					$display("test %s: ok", test_name[t]);
				else
					$display("test %s: %0d mismatches", test_name[t], errors - errs_before);
			end
		end

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
+incdir+bench
rtl/cpu_pkg.sv
rtl/pipe_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu.sv
bench/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build the CPU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module cpu_tb

out=$(./obj_dir/Vcpu_tb)
echo "$out"
echo "$out" | grep -qx "Testbench passed"
